/* verilog/ms6205_macros.svh */
`ifndef MS6205_MACROS_SVH
`define MS6205_MACROS_SVH

// ####################
// screen geometry
// ####################

`define COLUMNS 16
`define ROWS 10
`define MAX_POS 160

// ####################
// dekatron word sizes
// ####################

// one decimal digit per dekatron.
`define DEKATRON_WIDTH 4

`define IP_DEKATRON_NUM 5
`define AP_DEKATRON_NUM 5
`define DATA_DEKATRON_NUM 3
`define INSN_WIDTH 4

// ####################
// keyboard key indices
// ####################

// bit positions in the 40 key state vector.
`define KEYBOARD_IRAM_KEY 20
`define KEYBOARD_DRAM_KEY 21
`define KEYBOARD_CIO_KEY 22
`define KEYBOARD_HARD_RST 39

`endif

/* verilog/ms6205Pkg.sv */
package ms6205Pkg;

    // page codes as the terminal numbers them.
    typedef enum logic [2:0] {
        viewRestart = 3'b000,
        viewIram    = 3'b010,
        viewDram    = 3'b011,
        viewCio     = 3'b101
    } viewT;

    // with 16 columns the high nibble of the index is the row.
    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } gridPosT;

    typedef union packed {
        logic [7:0] index;  // linear position for the shadow memories.
        gridPosT    grid;   // row and column for the formatter.
    } screenPosT;

endpackage

/* verilog/viewSelect.sv */
`timescale 1ns/1ps

`include "ms6205_macros.svh"

module viewSelect
    import ms6205Pkg::*;
(
    input  logic        Clock_1us,
    input  logic        reset,
    input  logic        scanTick,
    input  logic [39:0] keysCurrentState,
    input  logic        cioAck,
    input  logic [2:0]  dpcState,
    output viewT        view,
    output logic        marker
);

    viewT nextView;

    // keys are levels, so the first one in this order wins.
    always_comb begin
        if (view == viewRestart) begin
            nextView = viewIram;
        end else if (keysCurrentState[`KEYBOARD_IRAM_KEY]) begin
            nextView = viewIram;
        end else if (keysCurrentState[`KEYBOARD_DRAM_KEY]) begin
            nextView = viewDram;
        end else if (keysCurrentState[`KEYBOARD_CIO_KEY] || cioAck) begin
            nextView = viewCio;  // console output pulls the console page up.
        end else if (keysCurrentState[`KEYBOARD_HARD_RST]) begin
            nextView = viewRestart;
        end else begin
            nextView = view;
        end
    end

    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            view <= viewRestart;
        end else if (scanTick) begin
            view <= nextView;
        end
    end

    // marker lights while the listing is shown in machine state 2.
    assign marker = (view == viewIram) && (dpcState == 3'd2);

    viewLegal: assert property (
        @(posedge Clock_1us) disable iff (reset)
        view inside {viewRestart, viewIram, viewDram, viewCio}
    ) else $error("view left the page encodings: %0d", view);

endmodule

/* verilog/screenCapture.sv */
`timescale 1ns/1ps

`include "ms6205_macros.svh"

module screenCapture
    import ms6205Pkg::*;
(
    input  logic        Clock_1us,
    input  logic        reset,
    input  logic        cout,
    input  logic [7:0]  symbol,
    input  viewT        view,
    input  screenPosT   scanPos,
    input  logic [19:0] ipAddressScan,
    input  logic [19:0] apAddressScan,
    input  logic [3:0]  romData,
    input  logic [11:0] apData,
    output logic        cioAck,
    output logic [7:0]  stdioChar,
    output logic [3:0]  insnCode,
    output logic [11:0] dataWord0,
    output logic [11:0] dataWord1
);

    localparam int dataWidth = `DATA_DEKATRON_NUM * `DEKATRON_WIDTH;
    localparam int dataEntries = 10;

    logic [7:0]              stdioRam [0:`MAX_POS-1];
    logic [`INSN_WIDTH-1:0]  insnRam  [0:`MAX_POS-1];
    logic [dataWidth-1:0]    dataRam  [0:dataEntries-1];

    logic [7:0] stdioAddr;
    logic       captureEn;
    logic [4:0] dataIdx0;
    logic [4:0] dataIdx1;

    // ####################
    // console capture
    // ####################

    assign captureEn = cout && !cioAck;

    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            stdioAddr <= 8'h00;
            cioAck    <= 1'b0;
        end else if (captureEn) begin
            cioAck <= 1'b1;
            if (stdioAddr == 8'(`MAX_POS - 1)) begin
                stdioAddr <= 8'h00;
            end else begin
                stdioAddr <= stdioAddr + 8'h01;
            end
        end else if (!cout && cioAck && (view == viewCio)) begin
            cioAck <= 1'b0;  // released only once the console page is up.
        end
    end

    // ####################
    // shadow memories
    // ####################

    always_ff @(posedge Clock_1us) begin
        if (captureEn) begin
            stdioRam[stdioAddr] <= symbol;
        end
        insnRam[ipAddressScan[7:0]] <= romData;  // low byte is always a scan position.
        if (apAddressScan[3:0] < 4'(dataEntries)) begin
            dataRam[apAddressScan[3:0]] <= apData;
        end
    end

    // each DRAM row shows a pair of words.
    assign dataIdx0 = {scanPos.grid.row, 1'b0};
    assign dataIdx1 = {scanPos.grid.row, 1'b1};

    assign stdioChar = stdioRam[scanPos.index];
    assign insnCode  = insnRam[scanPos.index];
    assign dataWord0 = (dataIdx0 < 5'(dataEntries)) ? dataRam[dataIdx0[3:0]] : '0;
    assign dataWord1 = (dataIdx1 < 5'(dataEntries)) ? dataRam[dataIdx1[3:0]] : '0;

    ackNeedsCout: assert property (
        @(posedge Clock_1us) disable iff (reset)
        $rose(cioAck) |-> $past(cout)
    ) else $error("cioAck rose without console output.");

endmodule

/* verilog/charGenerator.sv */
`timescale 1ns/1ps

`include "ms6205_macros.svh"

module charGenerator
    import ms6205Pkg::*;
(
    input  logic        Clock_1us,
    input  logic        reset,
    input  logic        scanTick,
    input  viewT        view,
    input  logic [19:0] ipAddress,
    input  logic [19:0] apAddress,
    input  logic [7:0]  stdioChar,
    input  logic [3:0]  insnCode,
    input  logic [11:0] dataWord0,
    input  logic [11:0] dataWord1,
    output screenPosT   scanPos,
    output logic [7:0]  address,
    output logic [7:0]  dataN,
    output logic [19:0] ipAddressScan,
    output logic [19:0] apAddressScan
);

    localparam int dw = `DEKATRON_WIDTH;
    localparam int ipWidth = `IP_DEKATRON_NUM * `DEKATRON_WIDTH;
    localparam int apWidth = `AP_DEKATRON_NUM * `DEKATRON_WIDTH;

    logic [7:0] charNext;

    function automatic logic [7:0] digitChar(input logic [dw-1:0] digit);
        return 8'h30 + {{(8 - dw){1'b0}}, digit};
    endfunction

    function automatic logic [7:0] opcodeChar(input logic [`INSN_WIDTH-1:0] op);
        case (op)
            4'd0:    return "+";
            4'd1:    return "-";
            4'd2:    return ">";
            4'd3:    return "<";
            4'd4:    return "[";
            4'd5:    return "]";
            4'd6:    return ".";
            4'd7:    return ",";
            default: return " ";
        endcase
    endfunction

    // ####################
    // character formatting
    // ####################

    always_comb begin
        charNext = " ";
        case (view)
            viewIram: begin
                case (scanPos.grid.col)
                    4'd0:    charNext = digitChar(ipAddressScan[4*dw +: dw]);
                    4'd1:    charNext = digitChar(ipAddressScan[3*dw +: dw]);
                    4'd2:    charNext = digitChar(ipAddressScan[2*dw +: dw]);
                    4'd3:    charNext = digitChar(ipAddressScan[1*dw +: dw]);
                    4'd4:    charNext = "0";
                    4'd5:    charNext = ":";
                    default: charNext = opcodeChar(insnCode);
                endcase
            end
            viewDram: begin
                if (scanPos.grid.row < 4'd5) begin  // lower half of the screen stays blank.
                    case (scanPos.grid.col)
                        4'd0:    charNext = digitChar(apAddressScan[4*dw +: dw]);
                        4'd1:    charNext = digitChar(apAddressScan[3*dw +: dw]);
                        4'd2:    charNext = digitChar(apAddressScan[2*dw +: dw]);
                        4'd3:    charNext = digitChar(apAddressScan[1*dw +: dw]);
                        4'd4:    charNext = digitChar(scanPos.grid.row);
                        4'd5:    charNext = ":";
                        4'd7:    charNext = digitChar(dataWord0[2*dw +: dw]);
                        4'd8:    charNext = digitChar(dataWord0[1*dw +: dw]);
                        4'd9:    charNext = digitChar(dataWord0[0 +: dw]);
                        4'd12:   charNext = digitChar(dataWord1[2*dw +: dw]);
                        4'd13:   charNext = digitChar(dataWord1[1*dw +: dw]);
                        4'd14:   charNext = digitChar(dataWord1[0 +: dw]);
                        default: charNext = " ";
                    endcase
                end
            end
            default: charNext = stdioChar;  // console text, also while restarting.
        endcase
    end

    // ####################
    // scan
    // ####################

    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            scanPos       <= '0;
            address       <= 8'h00;
            dataN         <= 8'h00;
            ipAddressScan <= '0;
            apAddressScan <= '0;
        end else if (scanTick) begin
            address       <= scanPos.index;
            dataN         <= ~charNext;  // the terminal bus is active low.
            ipAddressScan <= {ipAddress[ipWidth-1:2*dw], scanPos.index};
            apAddressScan <= {apAddress[apWidth-1:dw], scanPos.index[6:3]};
            if (scanPos.index == 8'(`MAX_POS - 1)) begin
                scanPos.index <= 8'h00;
            end else begin
                scanPos.index <= scanPos.index + 8'h01;
            end
        end
    end

    posInRange: assert property (
        @(posedge Clock_1us) disable iff (reset)
        scanPos.index < 8'(`MAX_POS)
    ) else $error("scan position %0d out of the screen.", scanPos.index);

endmodule

/* verilog/ms6205Display.sv */
`timescale 1ns/1ps

`include "ms6205_macros.svh"

module ms6205Display
    import ms6205Pkg::*;
(
    input  logic        Clock_1us,
    input  logic        reset,
    input  logic        scanTick,
    input  logic        cout,
    input  logic [7:0]  symbol,
    output logic        cioAck,
    input  logic [39:0] keysCurrentState,
    input  logic [2:0]  dpcState,
    input  logic [`IP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0]   ipAddress,
    input  logic [`AP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0]   apAddress,
    input  logic [`INSN_WIDTH-1:0]                        romData,
    input  logic [`DATA_DEKATRON_NUM*`DEKATRON_WIDTH-1:0] apData,
    output logic [7:0]  address,
    output logic [7:0]  dataN,
    output logic        marker,
    output logic [`IP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0]   ipAddressScan,
    output logic [`AP_DEKATRON_NUM*`DEKATRON_WIDTH-1:0]   apAddressScan
);

    viewT       view;
    screenPosT  scanPos;
    logic [7:0]  stdioChar;
    logic [3:0]  insnCode;
    logic [11:0] dataWord0;
    logic [11:0] dataWord1;

    viewSelect u_viewSelect (
        .Clock_1us(Clock_1us), .reset(reset), .scanTick(scanTick),
        .keysCurrentState(keysCurrentState), .cioAck(cioAck), .dpcState(dpcState),
        .view(view), .marker(marker)
    );

    screenCapture u_screenCapture (
        .Clock_1us(Clock_1us), .reset(reset), .cout(cout), .symbol(symbol),
        .view(view), .scanPos(scanPos),
        .ipAddressScan(ipAddressScan), .apAddressScan(apAddressScan),
        .romData(romData), .apData(apData), .cioAck(cioAck),
        .stdioChar(stdioChar), .insnCode(insnCode),
        .dataWord0(dataWord0), .dataWord1(dataWord1)
    );

    charGenerator u_charGenerator (
        .Clock_1us(Clock_1us), .reset(reset), .scanTick(scanTick), .view(view),
        .ipAddress(ipAddress), .apAddress(apAddress),
        .stdioChar(stdioChar), .insnCode(insnCode),
        .dataWord0(dataWord0), .dataWord1(dataWord1),
        .scanPos(scanPos), .address(address), .dataN(dataN),
        .ipAddressScan(ipAddressScan), .apAddressScan(apAddressScan)
    );

endmodule

/* tests/ms6205DisplayTb.sv */
`timescale 1ns/1ps

`include "ms6205_macros.svh"

module ms6205DisplayTb
    import ms6205Pkg::*;
;

    logic        Clock_1us;
    logic        reset;
    logic        scanTick;
    logic        cout;
    logic [7:0]  symbol;
    logic        cioAck;
    logic [39:0] keysCurrentState;
    logic [2:0]  dpcState;
    logic [19:0] ipAddress;
    logic [19:0] apAddress;
    logic [3:0]  romData;
    logic [11:0] apData;
    logic [7:0]  address;
    logic [7:0]  dataN;
    logic        marker;
    logic [19:0] ipAddressScan;
    logic [19:0] apAddressScan;

    logic [31:0] lfsrState;
    logic [1:0]  tickPhase;
    logic        timedOut;
    int addrErrors, dataErrors, viewErrors, markerErrors, ackErrors, resetErrors;

    // reference state, updated from the sampled inputs only.
    viewT              modelView;
    logic              modelAck;
    logic [7:0]        consoleMem [0:`MAX_POS-1];
    logic [`MAX_POS-1:0] consValid;
    logic [7:0]        consPtr;
    logic [7:0]        expPos;
    logic [7:0]        expAddr;
    logic [7:0]        expChar;
    logic              expValid;
    int                tickCount;

    ms6205Display u_dut (.*);

    always #50 Clock_1us = ~Clock_1us;

    // ####################
    // memory models
    // ####################

    function automatic logic [3:0] romModel(input logic [19:0] a);
        return a[3:0] ^ a[7:4] ^ a[11:8] ^ 4'd9;
    endfunction

    function automatic logic [11:0] dataModel(input logic [19:0] a);
        return {a[3:0] ^ a[7:4], a[3:0], a[11:8] + a[3:0]};
    endfunction

    assign romData = romModel(ipAddressScan);  // both memories answer at once.
    assign apData = dataModel(apAddressScan);

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
    endfunction

    function automatic viewT nextPage(input viewT page, input logic [39:0] keys, input logic ack);
        if (page == viewRestart) return viewIram;
        if (keys[`KEYBOARD_IRAM_KEY]) return viewIram;
        if (keys[`KEYBOARD_DRAM_KEY]) return viewDram;
        if (keys[`KEYBOARD_CIO_KEY] || ack) return viewCio;
        if (keys[`KEYBOARD_HARD_RST]) return viewRestart;
        return page;
    endfunction

    function automatic logic [7:0] expectedChar(input logic [7:0] pos, input viewT page);
        logic [63:0] opTable;
        logic [3:0]  row;
        logic [3:0]  col;
        logic [3:0]  op;
        logic [11:0] w0;
        logic [11:0] w1;
        int          sh;
        opTable = "+-><[].,";
        row = 4'(pos / `COLUMNS);
        col = 4'(pos % `COLUMNS);
        sh = 16 - 4 * int'(col);
        if (page == viewIram) begin
            op = romModel({ipAddress[19:8], pos});
            if (col < 4'd3) return 8'h30 + 8'(ipAddress[sh +: 4]);
            if (col == 4'd3) return 8'h30 + 8'(row);  // low digits hold the position.
            if (col == 4'd4) return "0";
            if (col == 4'd5) return ":";
            if (op < 4'd8) return opTable[8 * (7 - int'(op)) +: 8];
            return " ";
        end
        if (page == viewDram) begin
            w0 = dataModel({apAddress[19:4], 4'(2 * row)});
            w1 = dataModel({apAddress[19:4], 4'(2 * row + 1)});
            if (row > 4'd4) return " ";
            if (col < 4'd4) return 8'h30 + 8'(apAddress[sh +: 4]);
            if (col == 4'd4) return 8'h30 + 8'(row);
            if (col == 4'd5) return ":";
            if (col >= 4'd7 && col <= 4'd9) return 8'h30 + 8'(w0[4 * (9 - int'(col)) +: 4]);
            if (col >= 4'd12 && col <= 4'd14) return 8'h30 + 8'(w1[4 * (14 - int'(col)) +: 4]);
            return " ";
        end
        return consoleMem[pos];
    endfunction

    always @(posedge Clock_1us) begin
        if (reset) begin
            modelView <= viewRestart;
            modelAck  <= 1'b0;
            consValid <= '0;
            consPtr   <= 8'h00;
            expPos    <= 8'h00;
            expAddr   <= 8'h00;
            expChar   <= 8'h00;
            expValid  <= 1'b0;
            tickCount <= 0;
        end else begin
            if (cout && !modelAck) begin
                consoleMem[consPtr] <= symbol;
                consValid[consPtr]  <= 1'b1;
                consPtr  <= (consPtr == 8'(`MAX_POS - 1)) ? 8'h00 : consPtr + 8'd1;
                modelAck <= 1'b1;
            end else if (!cout && modelAck && modelView == viewCio) begin
                modelAck <= 1'b0;
            end
            if (scanTick) begin
                modelView <= nextPage(modelView, keysCurrentState, modelAck);
                expAddr   <= expPos;
                expChar   <= ~expectedChar(expPos, modelView);
                // shadow memories are complete after one frame.
                expValid  <= (tickCount >= `MAX_POS) &&
                             (modelView inside {viewIram, viewDram} || consValid[expPos]);
                expPos    <= (expPos == 8'(`MAX_POS - 1)) ? 8'h00 : expPos + 8'd1;
                tickCount <= tickCount + 1;
            end
        end
    end

    // ####################
    // checks
    // ####################

    resetValues: assert property (@(posedge Clock_1us)
        $fell(reset) |-> address == 8'h00 && dataN == 8'h00 && !cioAck && !marker)
    else begin
        resetErrors = resetErrors + 1;
        $display("Error at %0t: outputs not cleared by reset", $time);
    end

    addrStep: assert property (@(posedge Clock_1us) disable iff (reset)
        $past(scanTick) |-> address == expAddr)
    else begin
        addrErrors = addrErrors + 1;
        $display("Error at %0t: address %0d, expected %0d", $time, address, expAddr);
    end

    // the fetch addresses carry the scanned position in their low digits.
    scanAddrMatch: assert property (@(posedge Clock_1us) disable iff (reset)
        $past(scanTick) |-> ipAddressScan[19:8] == ipAddress[19:8]
            && ipAddressScan[7:0] == expAddr
            && apAddressScan[19:4] == apAddress[19:4]
            && apAddressScan[3:0] == expAddr[6:3])
    else begin
        addrErrors = addrErrors + 1;
        $display("Error at %0t: scan addresses %h and %h for position %0d",
                 $time, ipAddressScan, apAddressScan, expAddr);
    end

    charMatch: assert property (@(posedge Clock_1us) disable iff (reset)
        $past(scanTick) && expValid |-> dataN == expChar)
    else begin
        dataErrors = dataErrors + 1;
        $display("Error at %0t: dataN %h at %0d, expected %h", $time, dataN, address, expChar);
    end

    pageMatch: assert property (@(posedge Clock_1us) disable iff (reset)
        u_dut.view == modelView)
    else begin
        viewErrors = viewErrors + 1;
        $display("Error at %0t: view %0d, expected %0d", $time, u_dut.view, modelView);
    end

    markerMatch: assert property (@(posedge Clock_1us) disable iff (reset)
        marker == (modelView == viewIram && dpcState == 3'd2))
    else begin
        markerErrors = markerErrors + 1;
        $display("Error at %0t: marker %b with dpcState %0d", $time, marker, dpcState);
    end

    ackMatch: assert property (@(posedge Clock_1us) disable iff (reset)
        cioAck == modelAck)
    else begin
        ackErrors = ackErrors + 1;
        $display("Error at %0t: cioAck %b, expected %b", $time, cioAck, modelAck);
    end

    // ####################
    // stimulus
    // ####################

    task automatic drawBits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic stepCycle();
        logic [31:0] r;
        @(posedge Clock_1us);
        #1;
        tickPhase = tickPhase + 2'd1;
        scanTick = (tickPhase == 2'd0);  // one tick every four clocks.
        drawBits(3, r);
        dpcState = r[2:0];
    endtask

    task automatic waitTicks(input int n);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (!timedOut && seen < n) begin
            if (scanTick) seen++;
            stepCycle();
            cycles++;
            if (cycles > 8 * n + 8) begin
                timedOut = 1'b1;
                $display("The scan ticks stopped before %0d ticks had passed.", n);
            end
        end
    endtask

    task automatic sendSymbol();
        logic [31:0] r;
        int cycles;
        drawBits(8, r);
        symbol = r[7:0];
        cout = 1'b1;
        cycles = 0;
        while (!timedOut && !cioAck) begin
            stepCycle();
            cycles++;
            if (cycles > 50) begin
                timedOut = 1'b1;
                $display("cioAck never rose for a console symbol.");
            end
        end
        cout = 1'b0;
        cycles = 0;
        while (!timedOut && cioAck) begin
            stepCycle();
            cycles++;
            if (cycles > 50) begin
                timedOut = 1'b1;
                $display("cioAck stayed high after cout was dropped.");
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        int errSum;
        Clock_1us = 1'b0;
        reset = 1'b1;
        scanTick = 1'b0;
        cout = 1'b0;
        symbol = 8'h00;
        keysCurrentState = '0;
        dpcState = 3'd0;
        lfsrState = 32'ha84b4941;
        tickPhase = 2'd0;
        timedOut = 1'b0;
        {addrErrors, dataErrors, viewErrors, markerErrors, ackErrors, resetErrors} = '0;
        drawBits(20, r);
        ipAddress = r[19:0];
        drawBits(20, r);
        apAddress = r[19:0];
        stepCycle();
        stepCycle();
        reset = 1'b0;

        waitTicks(2 * `MAX_POS);  // listing page.
        keysCurrentState[`KEYBOARD_DRAM_KEY] = 1'b1;
        waitTicks(2 * `MAX_POS);
        keysCurrentState[`KEYBOARD_DRAM_KEY] = 1'b0;

        // enough symbols to wrap the console pointer.
        for (int i = 0; i < `MAX_POS + 5; i++) begin
            sendSymbol();
        end
        waitTicks(2 * `MAX_POS);

        keysCurrentState[`KEYBOARD_HARD_RST] = 1'b1;
        waitTicks(1);
        keysCurrentState[`KEYBOARD_HARD_RST] = 1'b0;
        waitTicks(4);

        errSum = addrErrors + dataErrors + viewErrors + markerErrors + ackErrors + resetErrors;
        $display("errors: address %0d, data %0d, view %0d, marker %0d, ack %0d, reset %0d",
                 addrErrors, dataErrors, viewErrors, markerErrors, ackErrors, resetErrors);
        if (!timedOut && errSum == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* ms6205Display.f */
+incdir+verilog
verilog/ms6205Pkg.sv
verilog/viewSelect.sv
verilog/screenCapture.sv
verilog/charGenerator.sv
verilog/ms6205Display.sv
tests/ms6205DisplayTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ms6205DisplayTb -f ms6205Display.f \
    && ./obj_dir/Vms6205DisplayTb | tee /dev/stderr | grep -q "^Test passed$" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
